// ==== Bender.yml ====
package:
  name: crc_accel

sources:
  - files:
      - verilog/crc_pkg.sv
      - verilog/crc_host_port.sv
      - verilog/crc_control_unit.sv
      - verilog/crc_input_buffer.sv
      - verilog/crc_engine.sv
      - verilog/crc_top.sv
  - target: test
    files:
      - bench/crc_chk.sv
      - bench/crc_tb.sv

// ==== bench/crc_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module crc_chk
(
  input wire clk,
  input wire rst_n,
  input wire req,
  input wire ack,
  input wire write,
  input wire buffer_full,
  input wire word_done
);

  int         fail_count = 0;
  logic [1:0] words_held;

  // Words written and not yet fully folded into the CRC
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      words_held <= 2'd0;
    else if (write && !word_done)
      words_held <= words_held + 2'd1;
    else if (!write && word_done)
      words_held <= words_held - 2'd1;
  end

  // Back-pressure only when both entries hold a word
  full_needs_two_words: assert property (@(posedge clk) disable iff (!rst_n)
    buffer_full |-> (words_held == 2'd2))
  else
  begin
    fail_count++;
    $error("buffer_full is high with fewer than two words buffered");
  end

  ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack) |-> $past(req))
  else
  begin
    fail_count++;
    $error("ack rose without a pending req");
  end

  // One strobe per accepted data write
  write_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    write |=> !write)
  else
  begin
    fail_count++;
    $error("write stayed high for two cycles");
  end

endmodule

bind crc_control_unit crc_chk u_chk_ctrl
(
  .clk         (clk),
  .rst_n       (rst_n),
  .req         (1'b0),
  .ack         (1'b0),
  .write       (write),
  .buffer_full (buffer_full),
  .word_done   (last_byte)
);

bind crc_host_port crc_chk u_chk_port
(
  .clk         (clk),
  .rst_n       (rst_n),
  .req         (req),
  .ack         (ack),
  .write       (write),
  .buffer_full (1'b0),
  .word_done   (1'b0)
);

`default_nettype wire

// ==== bench/crc_input.txt ====
// op addr data expected (op 0 write, 1 read and compare, plus 10 for no idle gap)
// addr 0 data, 1 ctrl (size in bits 1:0, reset chain in bit 4), 2 init, 3 crc
0 1 00000002 00000000
0 0 34333231 00000000
0 1 00000001 00000000
0 0 DEAD3635 00000000
0 0 BEEF3837 00000000
0 1 00000000 00000000
0 0 AABBCC39 00000000
1 3 00000000 0376E6E7
0 1 00000012 00000000
0 0 34333231 00000000
10 0 38373635 00000000
10 1 00000000 00000000
10 0 00000039 00000000
11 3 00000000 0376E6E7
10 1 00000002 00000000
10 0 E7E67603 00000000
11 3 00000000 00000000
0 2 00000000 00000000
1 2 00000000 00000000
0 1 00000010 00000000
0 0 55555501 00000000
1 3 00000000 04C11DB7
1 1 00000000 00000000

// ==== bench/crc_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module crc_tb;

  import crc_pkg::*;

  localparam int MAX_TRANS        = 64;
  localparam int RESET_CYCLES     = 8;
  localparam int CYCLES_PER_TRANS = 20;

  // Reference model constants, kept apart from the design
  localparam logic [31:0] MODEL_POLY = 32'h04C1_1DB7;
  localparam logic [31:0] MODEL_INIT = 32'hFFFF_FFFF;

  logic        clk;
  logic        rst_n;
  logic        req;
  logic        we;
  logic [1:0]  addr;
  logic [31:0] wdata;
  logic        ack;
  logic [31:0] rdata;

  // Four words per transaction: opcode, address, data, expected
  logic [31:0] stim [0:4*MAX_TRANS-1];
  int          num_trans;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  int          error_count = 0;
  int          check_count = 0;
  logic [31:0] lcg_state;

  logic [31:0] model_crc;
  logic [31:0] model_init;
  size_t       model_size;
  logic        model_restart;

  crc_top dut
  (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .we    (we),
    .addr  (addr),
    .wdata (wdata),
    .ack   (ack),
    .rdata (rdata)
  );

  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit)
    begin
      $display("Run did not finish within %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Byte enters at the top of the register, then eight shifts
  function automatic logic [31:0] fold_byte(input logic [31:0] crc, input logic [7:0] data);
    logic [31:0] acc;
    acc = crc ^ {data, 24'h0};
    for (int k = 0; k < 8; k++)
      acc = acc[31] ? ((acc << 1) ^ MODEL_POLY) : (acc << 1);
    return acc;
  endfunction

  task automatic model_write(input logic [1:0] a, input logic [31:0] d);
    host_word_u w;
    int         nbytes;
    w = d;
    case (a)
      ADDR_DATA:
      begin
        case (model_size)
          SIZE_BYTE: nbytes = 1;
          SIZE_HALF: nbytes = 2;
          default:   nbytes = 4;
        endcase
        if (model_restart)
          model_crc = model_init;
        model_restart = 1'b0;
        for (int k = 0; k < nbytes; k++)
          model_crc = fold_byte(model_crc, w.data_bytes[k]);
      end
      ADDR_CTRL:
      begin
        model_size = w.ctrl.size;
        if (w.ctrl.reset_chain)
          model_restart = 1'b1;
      end
      ADDR_INIT: model_init = d;
      default: ;
    endcase
  endtask

  function automatic logic [31:0] model_read(input logic [1:0] a);
    host_word_u w;
    w = '0;
    w.ctrl.size = model_size;
    case (a)
      ADDR_CTRL: return w;
      ADDR_INIT: return model_init;
      ADDR_CRC:  return model_crc;
      default:   return '0;
    endcase
  endfunction

  // Full four-phase access, returns the data seen while ack is high
  task automatic host_access(input logic is_read, input logic [1:0] a,
                             input logic [31:0] d, output logic [31:0] rd);
    @(posedge clk);
    req   <= 1'b1;
    we    <= !is_read;
    addr  <= a;
    wdata <= d;
    do
    begin
      @(negedge clk);
    end
    while (ack !== 1'b1);
    rd = rdata;
    @(posedge clk);
    req <= 1'b0;
    do
    begin
      @(negedge clk);
    end
    while (ack !== 1'b0);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    assert (got === exp)
    else
    begin
      error_count++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  initial
  begin
    logic [31:0] op;
    logic [1:0]  a;
    logic [31:0] d;
    logic [31:0] exp;
    logic [31:0] rd;
    int          chk_fails;

    clk   = 1'b0;
    rst_n = 1'b0;
    req   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    wdata = '0;
    lcg_state     = 32'h7409;
    model_crc     = '0;
    model_init    = MODEL_INIT;
    model_size    = SIZE_WORD;
    model_restart = 1'b1;

    $readmemh("bench/crc_input.txt", stim);
    num_trans = 0;
    while (num_trans < MAX_TRANS && !$isunknown(stim[4*num_trans]))
      num_trans++;
    assert (num_trans > 0)
    else
    begin
      error_count++;
      $display("No transactions could be read from the stimulus file");
    end
    cycle_limit = CYCLES_PER_TRANS * num_trans + RESET_CYCLES;

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    for (int t = 0; t < num_trans; t++)
    begin
      op  = stim[4*t];
      a   = stim[4*t+1][1:0];
      d   = stim[4*t+2];
      exp = stim[4*t+3];
      // Bit 4 of the opcode asks for a back-to-back access
      if (!op[4])
      begin
        lcg_state = lcg_next(lcg_state);
        repeat (int'(lcg_state[17:16])) @(posedge clk);
      end
      if (op[0])
      begin
        host_access(1'b1, a, '0, rd);
        check_value($sformatf("rdata (transaction %0d)", t), rd, exp);
        check_value($sformatf("model (transaction %0d)", t), model_read(a), exp);
      end
      else
      begin
        host_access(1'b0, a, d, rd);
        model_write(a, d);
      end
    end

    repeat (2) @(posedge clk);
    chk_fails = dut.u_control_unit.u_chk_ctrl.fail_count +
                dut.u_host_port.u_chk_port.fail_count;
    error_count += chk_fails;
    $display("Checks: %0d, checker failures: %0d, errors: %0d",
             check_count, chk_fails, error_count);
    if (error_count == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/crc_pkg.sv
verilog/crc_host_port.sv
verilog/crc_control_unit.sv
verilog/crc_input_buffer.sv
verilog/crc_engine.sv
verilog/crc_top.sv
bench/crc_chk.sv
bench/crc_tb.sv

// ==== verilog/crc_control_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module crc_control_unit
(
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire crc_pkg::size_t size_in,
  input  wire                 write,
  input  wire                 reset_chain,
  output logic [1:0]          byte_sel,
  output logic                bypass_byte0,
  output logic                buffer_full,
  output logic                read_wait,
  output logic                bypass_size,
  output logic                set_crc_init_sel,
  output logic                clear_crc_init_sel,
  output logic                crc_out_en,
  output logic                byte_en,
  output logic                reset_pending
);

  import crc_pkg::*;

  // Buffer occupancy
  typedef enum logic [1:0] {
    FILL_EMPTY,
    FILL_ONE,
    FILL_TWO,
    FILL_BYPASS
  } fill_state_t;

  // Idle sits above the byte lanes so the low bits give byte_sel directly
  typedef enum logic [2:0] {
    BYTE_0    = 3'b000,
    BYTE_1    = 3'b001,
    BYTE_2    = 3'b010,
    BYTE_3    = 3'b011,
    BYTE_IDLE = 3'b100
  } byte_state_t;

  typedef enum logic [2:0] {
    CHAIN_RUN,
    CHAIN_ARMED,
    CHAIN_WAIT,
    CHAIN_WRITE,
    CHAIN_REARM
  } chain_state_t;

  fill_state_t  fill_q;
  fill_state_t  fill_d;
  byte_state_t  byte_q;
  byte_state_t  byte_d;
  byte_state_t  word_end;
  chain_state_t chain_q;
  chain_state_t chain_d;
  logic         last_byte;
  logic         has_data;
  logic         next_word;
  logic         busy;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      fill_q  <= FILL_EMPTY;
      byte_q  <= BYTE_IDLE;
      chain_q <= CHAIN_RUN;
    end
    else
    begin
      fill_q  <= fill_d;
      byte_q  <= byte_d;
      chain_q <= chain_d;
    end
  end

  // Final byte of the current word for its size
  always_comb
  begin
    case (size_in)
      SIZE_BYTE: last_byte = (byte_q == BYTE_0);
      SIZE_HALF: last_byte = (byte_q == BYTE_1);
      default:   last_byte = (byte_q == BYTE_3);
    endcase
  end

  assign busy      = (byte_q != BYTE_IDLE);
  assign has_data  = (fill_q == FILL_TWO) || (fill_q == FILL_BYPASS);
  // Another word can start right after this one, with no idle cycle
  assign next_word = has_data || (write && !buffer_full);
  assign word_end  = next_word ? BYTE_0 : BYTE_IDLE;

  always_comb
  begin
    fill_d = fill_q;
    case (fill_q)
      FILL_EMPTY:
        if (write)
          fill_d = FILL_ONE;
      FILL_ONE:
        if (last_byte && !write)
          fill_d = FILL_EMPTY;
        else if (!last_byte && write)
          fill_d = FILL_TWO;
      FILL_TWO:
        if (last_byte)
          fill_d = write ? FILL_BYPASS : FILL_ONE;
      default:
        if (last_byte && !write)
          fill_d = FILL_ONE;
    endcase
  end

  always_comb
  begin
    byte_d = byte_q;
    case (byte_q)
      BYTE_IDLE:
        if (write)
          byte_d = BYTE_0;
      BYTE_0:  byte_d = last_byte ? word_end : BYTE_1;
      BYTE_1:  byte_d = last_byte ? word_end : BYTE_2;
      BYTE_2:  byte_d = BYTE_3;
      BYTE_3:  byte_d = word_end;
      default: byte_d = BYTE_IDLE;
    endcase
  end

  // A chain reset lands at the end of the last word written before the request
  always_comb
  begin
    chain_d = chain_q;
    case (chain_q)
      CHAIN_RUN:
        if (reset_chain && has_data)
          chain_d = last_byte ? CHAIN_ARMED : CHAIN_WAIT;
        else if (reset_chain && busy && !last_byte)
          chain_d = CHAIN_ARMED;
      CHAIN_ARMED:
        if (last_byte)
          chain_d = CHAIN_RUN;
        else if (write)
          chain_d = CHAIN_WRITE;
      CHAIN_WAIT:
        if (last_byte)
          chain_d = write ? CHAIN_WRITE : CHAIN_ARMED;
      CHAIN_WRITE:
        if (reset_chain)
          chain_d = last_byte ? CHAIN_ARMED : CHAIN_REARM;
        else if (last_byte)
          chain_d = CHAIN_RUN;
      default:
        if (last_byte)
          chain_d = write ? CHAIN_WRITE : CHAIN_ARMED;
    endcase
  end

  assign byte_sel     = byte_q[1:0];
  assign read_wait    = busy;
  assign crc_out_en   = busy;
  assign buffer_full  = has_data && !last_byte;

  // Byte 0 comes from the incoming entry unless a newer word already sits there
  assign bypass_byte0 = (fill_q != FILL_BYPASS);
  assign bypass_size  = (fill_q != FILL_BYPASS) && (byte_q == BYTE_0);

  // Move the word forward so the incoming entry is free for the next write
  assign byte_en = (byte_q == BYTE_0 && size_in != SIZE_BYTE && fill_q != FILL_BYPASS) ||
                   (last_byte && has_data);

  assign set_crc_init_sel = (byte_q == BYTE_0);

  assign clear_crc_init_sel =
    (reset_chain && !busy) ||
    (reset_chain && chain_q == CHAIN_RUN && last_byte && !has_data) ||
    (last_byte && (chain_q == CHAIN_ARMED || chain_q == CHAIN_WRITE ||
                   chain_q == CHAIN_REARM));

  assign reset_pending = (chain_q != CHAIN_RUN);

endmodule

`default_nettype wire

// ==== verilog/crc_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module crc_engine
(
  input  wire         clk,
  input  wire         rst_n,
  input  wire  [7:0]  crc_byte,
  input  wire  [31:0] init_value,
  input  wire         set_crc_init_sel,
  input  wire         clear_crc_init_sel,
  input  wire         crc_out_en,
  output logic [31:0] crc_out
);

  import crc_pkg::*;

  logic        chain_sel;
  logic [31:0] crc_start;
  logic [31:0] crc_next;

  // Chain select, clear wins over set
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      chain_sel <= 1'b0;
    else if (clear_crc_init_sel)
      chain_sel <= 1'b0;
    else if (set_crc_init_sel)
      chain_sel <= 1'b1;
  end

  assign crc_start = chain_sel ? crc_out : init_value;

  // Eight shift steps, data MSB first
  always_comb
  begin
    crc_next = crc_start;
    for (int i = 7; i >= 0; i--)
    begin
      if (crc_next[31] ^ crc_byte[i])
        crc_next = {crc_next[30:0], 1'b0} ^ CRC_POLY;
      else
        crc_next = {crc_next[30:0], 1'b0};
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      crc_out <= '0;
    else if (crc_out_en)
      crc_out <= crc_next;
  end

endmodule

`default_nettype wire

// ==== verilog/crc_host_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module crc_host_port
(
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 req,
  input  wire                 we,
  input  wire  [1:0]          addr,
  input  wire  [31:0]         wdata,
  output logic                ack,
  output logic [31:0]         rdata,
  input  wire                 buffer_full,
  input  wire                 read_wait,
  input  wire  [31:0]         crc_out,
  output logic                write,
  output crc_pkg::size_t      size_in,
  output logic                reset_chain,
  output logic [31:0]         data_word,
  output logic [31:0]         init_value
);

  import crc_pkg::*;

  host_word_u  host_word;
  host_word_u  ctrl_view;
  logic        access;
  logic        data_wr;
  logic        ctrl_wr;
  logic        init_wr;
  logic        crc_rd;
  logic        access_done;
  size_t       size_q;
  logic [31:0] init_q;

  assign host_word = wdata;

  // Request seen but not yet acknowledged
  assign access  = req && !ack;
  assign data_wr = we && (addr == ADDR_DATA);
  assign ctrl_wr = we && (addr == ADDR_CTRL);
  assign init_wr = we && (addr == ADDR_INIT);
  assign crc_rd  = !we && (addr == ADDR_CRC);

  // Data writes wait for buffer room, CRC reads wait for the last byte
  always_comb
  begin
    if (data_wr)
      access_done = !buffer_full;
    else if (crc_rd)
      access_done = !read_wait;
    else
      access_done = 1'b1;
  end

  assign write       = access && data_wr && !buffer_full;
  assign reset_chain = access && ctrl_wr && host_word.ctrl.reset_chain;
  assign data_word   = host_word.data_bytes;
  assign size_in     = size_q;
  assign init_value  = init_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      ack    <= 1'b0;
      size_q <= SIZE_WORD;
      init_q <= CRC_INIT_RESET;
    end
    else
    begin
      // Ack holds while req is high and falls the cycle after req drops
      if (ack)
        ack <= req;
      else
        ack <= req && access_done;
      if (access && ctrl_wr)
        size_q <= host_word.ctrl.size;
      if (access && init_wr)
        init_q <= wdata;
    end
  end

  always_comb
  begin
    ctrl_view = '0;
    ctrl_view.ctrl.size = size_q;
    case (addr)
      ADDR_CTRL: rdata = ctrl_view;
      ADDR_INIT: rdata = init_q;
      ADDR_CRC:  rdata = crc_out;
      default:   rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/crc_input_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module crc_input_buffer
(
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 write,
  input  wire  [31:0]         data_word,
  input  wire crc_pkg::size_t size_in,
  input  wire  [1:0]          byte_sel,
  input  wire                 bypass_byte0,
  input  wire                 bypass_size,
  input  wire                 byte_en,
  output logic [7:0]          crc_byte
);

  import crc_pkg::*;

  // Entry 0 feeds the engine, entry 1 takes host writes
  logic [3:0][7:0] entry0_data;
  logic [3:0][7:0] entry1_data;
  size_t           entry0_size;
  size_t           entry1_size;
  size_t           cur_size;
  logic [7:0]      lane;
  logic            lane_ok;

  always_ff @(posedge clk)
  begin
    if (write)
      entry1_data <= data_word;
    if (byte_en)
      entry0_data <= entry1_data;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      entry0_size <= SIZE_WORD;
      entry1_size <= SIZE_WORD;
    end
    else
    begin
      if (write)
        entry1_size <= size_in;
      if (byte_en)
        entry0_size <= entry1_size;
    end
  end

  always_comb
  begin
    if (byte_sel == 2'd0)
      lane = bypass_byte0 ? entry1_data[0] : entry0_data[0];
    else
      lane = entry0_data[byte_sel];
  end

  assign cur_size = bypass_size ? entry1_size : entry0_size;

  // Lanes beyond the word's size read as zero
  always_comb
  begin
    case (cur_size)
      SIZE_BYTE: lane_ok = (byte_sel == 2'd0);
      SIZE_HALF: lane_ok = !byte_sel[1];
      default:   lane_ok = 1'b1;
    endcase
  end

  assign crc_byte = lane_ok ? lane : 8'h00;

endmodule

`default_nettype wire

// ==== verilog/crc_pkg.sv ====
`default_nettype none

package crc_pkg;

  // Size of the data word written to ADDR_DATA
  typedef logic [1:0] size_t;

  localparam size_t SIZE_BYTE = 2'b00;
  localparam size_t SIZE_HALF = 2'b01;
  // Code 2'b11 is handled as a full word as well
  localparam size_t SIZE_WORD = 2'b10;

  // Host register map
  localparam logic [1:0] ADDR_DATA = 2'b00;
  localparam logic [1:0] ADDR_CTRL = 2'b01;
  localparam logic [1:0] ADDR_INIT = 2'b10;
  localparam logic [1:0] ADDR_CRC  = 2'b11;

  // CRC-32 generator, MSB first
  localparam logic [31:0] CRC_POLY       = 32'h04C1_1DB7;
  localparam logic [31:0] CRC_INIT_RESET = 32'hFFFF_FFFF;

  // Field layout of a CTRL write
  typedef struct packed {
    logic [26:0] reserved_hi;
    logic        reset_chain;
    logic [1:0]  reserved_lo;
    size_t       size;
  } ctrl_word_t;

  // Host word, read as data bytes or as control fields depending on the address
  typedef union packed {
    logic [3:0][7:0] data_bytes;
    ctrl_word_t      ctrl;
  } host_word_u;

endpackage

`default_nettype wire

// ==== verilog/crc_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module crc_top
(
  input  wire         clk,
  input  wire         rst_n,
  input  wire         req,
  input  wire         we,
  input  wire  [1:0]  addr,
  input  wire  [31:0] wdata,
  output logic        ack,
  output logic [31:0] rdata
);

  import crc_pkg::*;

  logic        write;
  size_t       size_in;
  logic        reset_chain;
  logic [31:0] data_word;
  logic [31:0] init_value;
  logic [31:0] crc_out;
  logic        buffer_full;
  logic        read_wait;
  logic [1:0]  byte_sel;
  logic        bypass_byte0;
  logic        bypass_size;
  logic        byte_en;
  logic        set_crc_init_sel;
  logic        clear_crc_init_sel;
  logic        crc_out_en;
  logic [7:0]  crc_byte;

  crc_host_port u_host_port
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .we          (we),
    .addr        (addr),
    .wdata       (wdata),
    .ack         (ack),
    .rdata       (rdata),
    .buffer_full (buffer_full),
    .read_wait   (read_wait),
    .crc_out     (crc_out),
    .write       (write),
    .size_in     (size_in),
    .reset_chain (reset_chain),
    .data_word   (data_word),
    .init_value  (init_value)
  );

  crc_control_unit u_control_unit
  (
    .clk                (clk),
    .rst_n              (rst_n),
    .size_in            (size_in),
    .write              (write),
    .reset_chain        (reset_chain),
    .byte_sel           (byte_sel),
    .bypass_byte0       (bypass_byte0),
    .buffer_full        (buffer_full),
    .read_wait          (read_wait),
    .bypass_size        (bypass_size),
    .set_crc_init_sel   (set_crc_init_sel),
    .clear_crc_init_sel (clear_crc_init_sel),
    .crc_out_en         (crc_out_en),
    .byte_en            (byte_en),
    .reset_pending      ()
  );

  crc_input_buffer u_input_buffer
  (
    .clk          (clk),
    .rst_n        (rst_n),
    .write        (write),
    .data_word    (data_word),
    .size_in      (size_in),
    .byte_sel     (byte_sel),
    .bypass_byte0 (bypass_byte0),
    .bypass_size  (bypass_size),
    .byte_en      (byte_en),
    .crc_byte     (crc_byte)
  );

  crc_engine u_engine
  (
    .clk                (clk),
    .rst_n              (rst_n),
    .crc_byte           (crc_byte),
    .init_value         (init_value),
    .set_crc_init_sel   (set_crc_init_sel),
    .clear_crc_init_sel (clear_crc_init_sel),
    .crc_out_en         (crc_out_en),
    .crc_out            (crc_out)
  );

endmodule

`default_nettype wire
